/* project.f */
drr_pkg.sv
drr_port_decode.sv
drr_quantum_div.sv
drr_flow_state.sv
drr_apb_regs.sv
drr_rank_top.sv
tb_drr_rank.sv

/* tb_drr_rank.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_drr_rank
    import drr_pkg::*;
();

    localparam int APB_WAIT_LIMIT = 8;
    localparam int DRAIN_LIMIT    = 4 * RANK_LATENCY + 40;

    typedef enum logic [1:0] {REC_WRITE, REC_READ, REC_PKT} rec_kind_e;

    typedef struct packed {
        rec_kind_e             kind;
        reg_field_e            field;
        logic [FLOW_ID_W-1:0]  flow;
        logic [APB_DATA_W-1:0] data;
        pkt_desc_t             pkt;
        logic                  exp_err;   // pslverr expected
    } test_rec_t;

    typedef struct packed {
        int unsigned due;                 // Cycle the rank must show up
        rank_t       rank;
    } pend_rank_t;

    logic                  clk_cp;
    logic                  rst;
    logic                  pkt_valid;
    pkt_desc_t             pkt;
    logic                  rank_valid;
    rank_t                 rank;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    int unsigned           cycle = 0;
    int                    error_count = 0;
    int                    timeout_count = 0;
    test_rec_t             rec_q [$];
    pend_rank_t            pend_q [$];
    pend_rank_t            mon_p;

    // Reference model of the DRR state
    logic [QUANTUM_W-1:0]  m_quant  [NUM_FLOWS];
    logic [ROUND_W-1:0]    m_round  [NUM_FLOWS];
    logic [QUANTUM_W-1:0]  m_remain [NUM_FLOWS];

    drr_rank_top dut_i (
        .clk_cp       (clk_cp),
        .rst          (rst),
        .pkt_valid_i  (pkt_valid),
        .pkt_i        (pkt),
        .rank_valid_o (rank_valid),
        .rank_o       (rank),
        .psel_i       (psel),
        .penable_i    (penable),
        .pwrite_i     (pwrite),
        .paddr_i      (paddr),
        .pwdata_i     (pwdata),
        .prdata_o     (prdata),
        .pready_o     (pready),
        .pslverr_o    (pslverr)
    );

    always #2 clk_cp = ~clk_cp;

    always @(posedge clk_cp)
    begin
        cycle <= cycle + 1;
    end

    //////////////////////////////
    // Reference rules
    //////////////////////////////

    function automatic int unsigned port_number(input logic [PORT_INFO_W-1:0] info);
        case (info)
            8'h01:   return 0;
            8'h04:   return 1;
            8'h10:   return 2;
            8'h40:   return 3;
            default: return 4;   // CPU port
        endcase
    endfunction

    function automatic logic access_fails(input logic wr, input reg_field_e field,
                                          input logic [FLOW_ID_W-1:0] flow,
                                          input logic [APB_DATA_W-1:0] data);
        if (flow >= NUM_FLOWS || field == FIELD_RSVD)
            return 1'b1;
        if (wr && field != FIELD_QUANTUM)
            return 1'b1;
        return wr && (data[QUANTUM_W-1:0] == '0);   // Zero quantum rejected
    endfunction

    function automatic logic [APB_DATA_W-1:0] expected_read(input reg_field_e field,
                                                            input logic [FLOW_ID_W-1:0] flow);
        case (field)
            FIELD_QUANTUM: return APB_DATA_W'(m_quant[flow]);
            FIELD_ROUND:   return APB_DATA_W'(m_round[flow]);
            FIELD_REMAIN:  return APB_DATA_W'(m_remain[flow]);
            default:       return '0;
        endcase
    endfunction

    task automatic model_packet(input pkt_desc_t p, output rank_t r);
        int unsigned flow;
        int unsigned q;
        int unsigned quo;
        int unsigned rem;
        flow = port_number(p.port_info) * NUM_CLASSES + p.pkt_class;
        q    = m_quant[flow];
        quo  = p.pkt_size / q;
        rem  = p.pkt_size % q;
        if (m_remain[flow] < rem)
        begin
            // Short of credit gives one extra round
            m_remain[flow] = m_remain[flow] + q - rem;
            m_round[flow]  = m_round[flow] + 1 + quo;
        end
        else
        begin
            m_remain[flow] = m_remain[flow] - rem;
            m_round[flow]  = m_round[flow] + quo;
        end
        r.flow_id = FLOW_ID_W'(flow);
        r.round   = m_round[flow];
    endtask

    //////////////////////////////
    // Stimulus table
    //////////////////////////////

    function automatic void write_rec(input reg_field_e field, input int flow, input int data);
        test_rec_t rec;
        rec         = '0;
        rec.kind    = REC_WRITE;
        rec.field   = field;
        rec.flow    = FLOW_ID_W'(flow);
        rec.data    = APB_DATA_W'(data);
        rec.exp_err = access_fails(1'b1, field, rec.flow, rec.data);
        rec_q.push_back(rec);
    endfunction

    function automatic void read_rec(input reg_field_e field, input int flow);
        test_rec_t rec;
        rec         = '0;
        rec.kind    = REC_READ;
        rec.field   = field;
        rec.flow    = FLOW_ID_W'(flow);
        rec.exp_err = access_fails(1'b0, field, rec.flow, '0);
        rec_q.push_back(rec);
    endfunction

    function automatic void packet_rec(input logic [7:0] info, input int cls, input int size);
        test_rec_t rec;
        rec               = '0;
        rec.kind          = REC_PKT;
        rec.pkt.port_info = info;
        rec.pkt.pkt_class = CLASS_W'(cls);
        rec.pkt.pkt_size  = PKT_SIZE_W'(size);
        rec_q.push_back(rec);
    endfunction

    task automatic build_table();
        logic [7:0] pats [5] = '{8'h01, 8'h04, 8'h10, 8'h40, 8'h22};
        int         flows [5] = '{0, 33, 66, 99, 136};
        int         quanta [5] = '{100, 256, 7, 1500, 3};
        // Reset state
        read_rec(FIELD_QUANTUM, 0);
        read_rec(FIELD_ROUND, 0);
        read_rec(FIELD_REMAIN, 0);
        read_rec(FIELD_QUANTUM, 159);
        read_rec(FIELD_ROUND, 77);
        read_rec(FIELD_REMAIN, 159);
        for (int k = 0; k < 5; k++)
        begin
            write_rec(FIELD_QUANTUM, flows[k], quanta[k]);
            read_rec(FIELD_QUANTUM, flows[k]);
        end
        packet_rec(8'h01, 0, 150);   // Remain 0 below 50 gives an extra round
        packet_rec(8'h01, 0, 30);
        packet_rec(8'h01, 0, 60);    // Short again
        packet_rec(8'h04, 1, 700);
        packet_rec(8'h10, 2, 20);
        packet_rec(8'h40, 3, 1499);
        packet_rec(8'h22, 8, 10);    // Undefined pattern maps to the CPU port
        for (int k = 0; k < 12; k++)
        begin
            packet_rec(pats[k % 5], flows[k % 5] % NUM_CLASSES, $urandom % 2048);
        end
        for (int k = 0; k < 6; k++)
        begin
            packet_rec(8'h10, 2, $urandom % 64 + 1);   // Same flow back to back
        end
        for (int k = 0; k < 5; k++)
        begin
            read_rec(FIELD_ROUND, flows[k]);
            read_rec(FIELD_REMAIN, flows[k]);
        end
        // Rejected accesses
        write_rec(FIELD_QUANTUM, 66, 0);
        read_rec(FIELD_QUANTUM, 66);
        write_rec(FIELD_ROUND, 66, 5);
        read_rec(FIELD_ROUND, 66);
        read_rec(FIELD_QUANTUM, 200);
        write_rec(FIELD_QUANTUM, 200, 9);
        read_rec(FIELD_RSVD, 66);
        write_rec(FIELD_RSVD, 66, 4);
        read_rec(FIELD_QUANTUM, 66);
        read_rec(FIELD_REMAIN, 66);
    endtask

    //////////////////////////////
    // Drivers
    //////////////////////////////

    task automatic apb_transfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                                input logic [APB_DATA_W-1:0] wdata,
                                output logic [APB_DATA_W-1:0] rdata, output logic err);
        int waits;
        psel    = 1'b1;   // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk_cp);
        penable = 1'b1;
        #1;
        waits = 0;
        while (!pready && waits < APB_WAIT_LIMIT)
        begin
            @(negedge clk_cp);
            #1;
            waits++;
        end
        if (!pready)
        begin
            $display("timeout: APB slave never raised pready at address %0h", addr);
            timeout_count++;
        end
        assert (pready && waits == 0)
        else
        begin
            $display("error %0t: pready not high in the first access cycle", $time);
            error_count++;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk_cp);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic send_packet(input pkt_desc_t p, input rank_t exp_rank);
        pend_rank_t pend;
        pkt       = p;
        pkt_valid = 1'b1;
        pend.due  = cycle + RANK_LATENCY;
        pend.rank = exp_rank;
        pend_q.push_back(pend);
        @(negedge clk_cp);
        pkt_valid = 1'b0;   // Next packet may raise it again at once
    endtask

    task automatic wait_drain();
        int waits;
        waits = 0;
        while (pend_q.size() != 0 && waits < DRAIN_LIMIT)
        begin
            @(negedge clk_cp);
            waits++;
        end
        if (pend_q.size() != 0)
        begin
            $display("timeout: %0d ranks never came out of the DUT", pend_q.size());
            timeout_count++;
            pend_q.delete();
        end
    endtask

    task automatic apply_record(input test_rec_t rec);
        logic [APB_DATA_W-1:0] rdata;
        logic                  err;
        rank_t                 exp_rank;
        if (rec.kind == REC_PKT)
        begin
            model_packet(rec.pkt, exp_rank);
            send_packet(rec.pkt, exp_rank);
        end
        else
        begin
            wait_drain();   // Readbacks see the settled state
            apb_transfer(rec.kind == REC_WRITE, {rec.field, rec.flow, 2'b00}, rec.data,
                         rdata, err);
            assert (err == rec.exp_err)
            else
            begin
                $display("error %0t: pslverr %0b, expected %0b (field %0d flow %0d)",
                         $time, err, rec.exp_err, rec.field, rec.flow);
                error_count++;
            end
            if (!rec.exp_err && rec.kind == REC_WRITE)
                m_quant[rec.flow] = rec.data[QUANTUM_W-1:0];
            else if (!rec.exp_err)
            begin
                assert (rdata == expected_read(rec.field, rec.flow))
                else
                begin
                    $display("error %0t: read %0h from field %0d flow %0d, expected %0h",
                             $time, rdata, rec.field, rec.flow,
                             expected_read(rec.field, rec.flow));
                    error_count++;
                end
            end
        end
    endtask

    // Rank monitor checks latency and value
    always @(negedge clk_cp)
    begin
        if (rst && rank_valid)
        begin
            assert (pend_q.size() != 0)
            else
            begin
                $display("error %0t: rank output with no packet pending", $time);
                error_count++;
            end
            if (pend_q.size() != 0)
            begin
                mon_p = pend_q.pop_front();
                assert (cycle == mon_p.due)
                else
                begin
                    $display("error %0t: rank at cycle %0d, expected %0d", $time, cycle,
                             mon_p.due);
                    error_count++;
                end
                assert (rank == mon_p.rank)
                else
                begin
                    $display("error %0t: rank flow %0d round %0d, expected flow %0d round %0d",
                             $time, rank.flow_id, rank.round, mon_p.rank.flow_id,
                             mon_p.rank.round);
                    error_count++;
                end
            end
        end
        else if (rst && pend_q.size() != 0)
        begin
            assert (cycle < pend_q[0].due)
            else
            begin
                $display("error %0t: no rank for flow %0d", $time, pend_q[0].rank.flow_id);
                error_count++;
                void'(pend_q.pop_front());
            end
        end
    end

    initial
    begin
        clk_cp    = 1'b0;
        rst       = 1'b0;
        pkt_valid = 1'b0;
        pkt       = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        void'($urandom(3000));
        for (int f = 0; f < NUM_FLOWS; f++)
        begin
            m_quant[f]  = DEFAULT_QUANTUM;
            m_round[f]  = '0;
            m_remain[f] = '0;
        end
        build_table();
        repeat (10) @(negedge clk_cp);
        rst = 1'b1;
        @(negedge clk_cp);
        assert (!rank_valid && !pready && !pslverr)
        else
        begin
            $display("error %0t: rank_valid %0b pready %0b pslverr %0b, expected low",
                     $time, rank_valid, pready, pslverr);
            error_count++;
        end
        foreach (rec_q[i])
        begin
            apply_record(rec_q[i]);
        end
        wait_drain();
        $display("checks done: %0d errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* drr_rank_top.sv */
`timescale 1ns/10ps
`default_nettype none

module drr_rank_top
    import drr_pkg::*;
(
    input  wire logic                  clk_cp,
    input  wire logic                  rst,
    // Packet path
    input  wire logic                  pkt_valid_i,
    input  wire pkt_desc_t             pkt_i,
    output logic                       rank_valid_o,
    output rank_t                      rank_o,
    // APB control port
    input  wire logic                  psel_i,
    input  wire logic                  penable_i,
    input  wire logic                  pwrite_i,
    input  wire logic [APB_ADDR_W-1:0] paddr_i,
    input  wire logic [APB_DATA_W-1:0] pwdata_i,
    output logic [APB_DATA_W-1:0]      prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o
);

    logic [FLOW_ID_W-1:0] lookup_flow_id;
    logic [QUANTUM_W-1:0] lookup_quantum;
    logic [FLOW_ID_W-1:0] stat_idx;
    flow_stat_t           stat;
    flow_job_t            dec_job;   // Stage 1 out
    div_job_t             div_job;   // Stage 12 out

    drr_port_decode u_port_decode (
        .clk_cp      (clk_cp),
        .rst         (rst),
        .pkt_valid_i (pkt_valid_i),
        .pkt_i       (pkt_i),
        .quantum_i   (lookup_quantum),
        .flow_id_o   (lookup_flow_id),
        .job_o       (dec_job)
    );

    drr_quantum_div u_quantum_div (
        .clk_cp (clk_cp),
        .rst    (rst),
        .job_i  (dec_job),
        .job_o  (div_job)
    );

    drr_flow_state u_flow_state (
        .clk_cp       (clk_cp),
        .rst          (rst),
        .job_i        (div_job),
        .stat_idx_i   (stat_idx),
        .stat_o       (stat),
        .rank_valid_o (rank_valid_o),
        .rank_o       (rank_o)
    );

    drr_apb_regs u_apb_regs (
        .clk_cp     (clk_cp),
        .rst        (rst),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .flow_id_i  (lookup_flow_id),
        .quantum_o  (lookup_quantum),
        .stat_idx_o (stat_idx),
        .stat_i     (stat)
    );

endmodule

`default_nettype wire

/* drr_apb_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module drr_apb_regs
    import drr_pkg::*;
(
    input  wire logic                  clk_cp,
    input  wire logic                  rst,
    input  wire logic                  psel_i,
    input  wire logic                  penable_i,
    input  wire logic                  pwrite_i,
    input  wire logic [APB_ADDR_W-1:0] paddr_i,
    input  wire logic [APB_DATA_W-1:0] pwdata_i,
    output logic [APB_DATA_W-1:0]      prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,
    input  wire logic [FLOW_ID_W-1:0]  flow_id_i,    // Stage 1 lookup
    output logic [QUANTUM_W-1:0]       quantum_o,
    output logic [FLOW_ID_W-1:0]       stat_idx_o,
    input  wire flow_stat_t            stat_i
);

    reg_field_e           field;
    logic [FLOW_ID_W-1:0] addr_flow;
    logic                 access;
    logic                 bad_flow;
    logic                 bad_write;
    logic                 slv_err;
    logic [QUANTUM_W-1:0] quant_tbl [NUM_FLOWS];

    //////////////////////////////
    // Address decode and checks
    //////////////////////////////

    assign field     = reg_field_e'(paddr_i[APB_ADDR_W-1 -: 2]);
    assign addr_flow = paddr_i[2 +: FLOW_ID_W];   // paddr[1:0] ignored
    assign access    = psel_i && penable_i;        // Access phase

    assign bad_flow  = (addr_flow >= NUM_FLOWS);
    // Only the quantum is writable, and never with zero
    assign bad_write = pwrite_i &&
                       ((field != FIELD_QUANTUM) || (pwdata_i[QUANTUM_W-1:0] == '0));
    assign slv_err   = bad_flow || (field == FIELD_RSVD) || bad_write;

    assign pready_o   = access;   // No wait states
    assign pslverr_o  = access && slv_err;
    assign stat_idx_o = addr_flow;

    //////////////////////////////
    // Quantum table
    //////////////////////////////

    always_ff @(posedge clk_cp)
    begin
        if (!rst)
        begin
            for (int i = 0; i < NUM_FLOWS; i++)
            begin
                quant_tbl[i] <= DEFAULT_QUANTUM;
            end
        end
        else if (access && pwrite_i && !slv_err)
        begin
            quant_tbl[addr_flow] <= pwdata_i[QUANTUM_W-1:0];
        end
    end

    assign quantum_o = quant_tbl[flow_id_i];   // Decode never yields an unused id

    // Read data, zero extended
    always_comb
    begin
        prdata_o = '0;
        if (access && !pwrite_i && !slv_err)
        begin
            case (field)
                FIELD_QUANTUM: prdata_o = APB_DATA_W'(quant_tbl[addr_flow]);
                FIELD_ROUND:   prdata_o = APB_DATA_W'(stat_i.round);
                FIELD_REMAIN:  prdata_o = APB_DATA_W'(stat_i.remain);
                default:       prdata_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* drr_flow_state.sv */
`timescale 1ns/10ps
`default_nettype none

module drr_flow_state
    import drr_pkg::*;
(
    input  wire logic                 clk_cp,
    input  wire logic                 rst,
    input  wire div_job_t             job_i,
    input  wire logic [FLOW_ID_W-1:0] stat_idx_i,   // Readback index from APB
    output flow_stat_t                stat_o,
    output logic                      rank_valid_o,
    output rank_t                     rank_o
);

    //////////////////////////////
    // Per-flow DRR state
    //////////////////////////////

    flow_stat_t           state_tbl [NUM_FLOWS];
    flow_stat_t           cur_stat;
    flow_stat_t           next_stat;
    logic                 short_remain;
    logic [ROUND_W-1:0]   round_add;

    // Read, update and write all in this stage, so a packet
    // directly behind one of the same flow sees its result
    assign cur_stat     = state_tbl[job_i.flow_id];
    assign short_remain = (cur_stat.remain < job_i.remainder);
    assign round_add    = ROUND_W'(job_i.quotient);

    always_comb
    begin
        if (short_remain)
        begin
            // Not enough credit left, borrow one more round
            next_stat.remain = cur_stat.remain + job_i.quantum - job_i.remainder;
            next_stat.round  = cur_stat.round + ROUND_W'(1) + round_add;
        end
        else
        begin
            next_stat.remain = cur_stat.remain - job_i.remainder;
            next_stat.round  = cur_stat.round + round_add;   // Wraps
        end
    end

    //////////////////////////////
    // State table and rank valid
    //////////////////////////////

    always_ff @(posedge clk_cp)
    begin
        if (!rst)
        begin
            for (int i = 0; i < NUM_FLOWS; i++)
            begin
                state_tbl[i] <= '0;
            end
            rank_valid_o <= 1'b0;
        end
        else
        begin
            if (job_i.valid)
            begin
                state_tbl[job_i.flow_id] <= next_stat;
            end
            rank_valid_o <= job_i.valid;   // One pulse per packet
        end
    end

    // Rank payload
    always_ff @(posedge clk_cp)
    begin
        if (job_i.valid)
        begin
            rank_o.flow_id <= job_i.flow_id;
            rank_o.round   <= next_stat.round;
        end
    end

    // Readback for the register block, zero for unused ids
    always_comb
    begin
        if (stat_idx_i < NUM_FLOWS)
        begin
            stat_o = state_tbl[stat_idx_i];
        end
        else
        begin
            stat_o = '0;
        end
    end

endmodule

`default_nettype wire

/* drr_quantum_div.sv */
`timescale 1ns/10ps
`default_nettype none

module drr_quantum_div
    import drr_pkg::*;
(
    input  wire logic      clk_cp,
    input  wire logic      rst,
    input  wire flow_job_t job_i,
    output div_job_t       job_o
);

    //////////////////////////////
    // Restoring divider, unrolled
    //////////////////////////////

    // The quotient field starts as the dividend. Each stage shifts one
    // dividend bit out at the top and one quotient bit in at the bottom,
    // so after DIV_STAGES shifts it holds the full quotient.

    div_job_t entry;
    div_job_t stage_q [DIV_STAGES];

    always_comb
    begin
        entry.valid     = job_i.valid;
        entry.flow_id   = job_i.flow_id;
        entry.quantum   = job_i.quantum;
        entry.quotient  = job_i.pkt_size;
        entry.remainder = '0;
    end

    for (genvar s = 0; s < DIV_STAGES; s++)
    begin : g_stage
        div_job_t             src;
        div_job_t             nxt;
        logic [QUANTUM_W:0]   trial;     // Partial remainder with next dividend bit
        logic [QUANTUM_W:0]   divisor;
        logic                 fits;

        if (s == 0)
        begin : g_first
            assign src = entry;
        end
        else
        begin : g_next
            assign src = stage_q[s-1];
        end

        assign divisor = {1'b0, src.quantum};
        assign trial   = {src.remainder, src.quotient[PKT_SIZE_W-1]};
        assign fits    = (trial >= divisor);

        always_comb
        begin
            nxt = src;
            if (fits)
            begin
                nxt.remainder = QUANTUM_W'(trial - divisor);
            end
            else
            begin
                nxt.remainder = trial[QUANTUM_W-1:0];   // Restore
            end
            nxt.quotient = {src.quotient[PKT_SIZE_W-2:0], fits};
        end

        // Payload flows freely, only valid is cleared
        always_ff @(posedge clk_cp)
        begin
            stage_q[s] <= nxt;
            if (!rst)
            begin
                stage_q[s].valid <= 1'b0;
            end
        end
    end

    assign job_o = stage_q[DIV_STAGES-1];   // Final quotient and remainder

endmodule

`default_nettype wire

/* drr_port_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module drr_port_decode
    import drr_pkg::*;
(
    input  wire logic                 clk_cp,
    input  wire logic                 rst,
    input  wire logic                 pkt_valid_i,
    input  wire pkt_desc_t            pkt_i,
    input  wire logic [QUANTUM_W-1:0] quantum_i,   // From the quantum table
    output logic [FLOW_ID_W-1:0]      flow_id_o,
    output flow_job_t                 job_o
);

    logic [PORT_ID_W-1:0] port_id;
    flow_job_t            job_d;

    // Network ports sit on every second bit
    always_comb
    begin
        case (pkt_i.port_info)
            8'h01:   port_id = PORT_ID_W'(0);
            8'h04:   port_id = PORT_ID_W'(1);
            8'h10:   port_id = PORT_ID_W'(2);
            8'h40:   port_id = PORT_ID_W'(3);
            default: port_id = PORT_ID_W'(NUM_PORTS - 1);   // CPU port
        endcase
    end

    assign flow_id_o = {port_id, pkt_i.pkt_class};

    always_comb
    begin
        job_d.valid    = pkt_valid_i;
        job_d.flow_id  = flow_id_o;
        job_d.quantum  = quantum_i;   // Quantum is fixed for this packet here
        job_d.pkt_size = pkt_i.pkt_size;
    end

    always_ff @(posedge clk_cp)
    begin
        job_o <= job_d;
        if (!rst)
        begin
            job_o.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* drr_pkg.sv */
`default_nettype none

package drr_pkg;

    //////////////////////////////
    // Widths and counts
    //////////////////////////////
    localparam int PORT_INFO_W = 8;                  // One-hot ingress port pattern
    localparam int NUM_PORTS   = 5;                  // Four network ports plus CPU
    localparam int PORT_ID_W   = 3;
    localparam int CLASS_W     = 5;
    localparam int NUM_CLASSES = 32;
    localparam int FLOW_ID_W   = PORT_ID_W + CLASS_W;      // {port, class}
    localparam int NUM_FLOWS   = NUM_PORTS * NUM_CLASSES;  // 160 used ids
    localparam int PKT_SIZE_W  = 11;
    localparam int QUANTUM_W   = 17;                 // Quantum and remaining quantum
    localparam int ROUND_W     = 17;                 // Wraps, no overflow bits

    localparam logic [QUANTUM_W-1:0] DEFAULT_QUANTUM = QUANTUM_W'(1);

    // Pipeline depth
    localparam int DIV_STAGES   = PKT_SIZE_W;        // One quotient bit per stage
    localparam int RANK_LATENCY = DIV_STAGES + 2;    // Decode, divider, DRR update

    // APB control port
    localparam int APB_ADDR_W = 12;
    localparam int APB_DATA_W = 32;

    // Register field in paddr[11:10]
    typedef enum logic [1:0] {
        FIELD_QUANTUM = 2'd0,   // Read and write
        FIELD_ROUND   = 2'd1,
        FIELD_REMAIN  = 2'd2,
        FIELD_RSVD    = 2'd3
    } reg_field_e;

    //////////////////////////////
    // Pipeline payloads
    //////////////////////////////
    typedef struct packed {
        logic [PKT_SIZE_W-1:0]  pkt_size;
        logic [PORT_INFO_W-1:0] port_info;
        logic [CLASS_W-1:0]     pkt_class;
    } pkt_desc_t;

    // Stage 1 into the divider
    typedef struct packed {
        logic                  valid;
        logic [FLOW_ID_W-1:0]  flow_id;
        logic [QUANTUM_W-1:0]  quantum;
        logic [PKT_SIZE_W-1:0] pkt_size;
    } flow_job_t;

    // Divider into the DRR update
    typedef struct packed {
        logic                  valid;
        logic [FLOW_ID_W-1:0]  flow_id;
        logic [QUANTUM_W-1:0]  quantum;
        logic [PKT_SIZE_W-1:0] quotient;
        logic [QUANTUM_W-1:0]  remainder;
    } div_job_t;

    typedef struct packed {
        logic [FLOW_ID_W-1:0] flow_id;
        logic [ROUND_W-1:0]   round;
    } rank_t;

    // Per-flow DRR state
    typedef struct packed {
        logic [ROUND_W-1:0]   round;
        logic [QUANTUM_W-1:0] remain;
    } flow_stat_t;

endpackage

`default_nettype wire
